/* mem_unit.f */
+incdir+verilog
verilog/lsq_pkg.sv
verilog/load_align.sv
verilog/data_mem.sv
verilog/lsq.sv
verilog/mem_unit.sv
verif/mem_unit_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the memory stage testbench with Verilator

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal -f mem_unit.f \
    --top-module mem_unit_tb -o mem_unit_sim > build.log 2>&1
if [ $? -ne 0 ]; then
    cat build.log
    echo "compile failed"
    exit 1
fi

./obj_dir/mem_unit_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Testbench failed" "$LOG"; then
    exit 1
fi
exit 0

/* verif/mem_unit_tb.sv */
`include "lsq_config.svh"
`default_nettype none

module mem_unit_tb
    import lsq_pkg::*;
;

    localparam int NTAGS = 1 << `LSQ_TAG_W;

    // one queued entry as the ROB side sees it
    typedef struct packed {
        logic [`LSQ_TAG_W-1:0] tag;
        mem_op_t               op;
        logic [31:0]           base;
        logic [31:0]           data;
        logic [31:0]           addr;
        logic                  pend1;
        logic                  pend2;
        logic [2:0]            cnt1;
        logic [2:0]            cnt2;
    } model_entry;

    logic                  clk;
    logic                  rst;
    logic                  load;
    res_word               res_in;
    logic                  flush_ip;
    cdb_data               cdb [NTAGS];
    logic [NTAGS-1:0]      robs_calculated;
    logic [`LSQ_TAG_W-1:0] rob_head_ptr;
    logic                  full;
    logic                  finished_entry;
    finished_word          finished_data;

    model_entry            q[$];
    logic [31:0]           mirror [`LSQ_MEM_WORDS];
    integer                seed;
    int                    errors;
    int                    timeouts;
    int                    finishes;
    int                    idle_cycles;
    logic [`LSQ_TAG_W-1:0] next_tag;
    bit                    full_check;

    mem_unit dut0 (
        .clk             (clk),
        .rst             (rst),
        .load            (load),
        .res_in          (res_in),
        .flush_ip        (flush_ip),
        .cdb             (cdb),
        .robs_calculated (robs_calculated),
        .rob_head_ptr    (rob_head_ptr),
        .full            (full),
        .finished_entry  (finished_entry),
        .finished_data   (finished_data)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic logic [31:0] expect_load(mem_op_t op, logic [31:0] word,
                                                logic [1:0] off);
        logic [7:0]  b;
        logic [15:0] h;
        b = word[8*off +: 8];
        h = off[1] ? word[31:16] : word[15:0];
        case (op)
            LB: return {{24{b[7]}}, b};
            LBU: return {24'h000000, b};
            LH: return {{16{h[15]}}, h};
            LHU: return {16'h0000, h};
            LW: return word;
            default: return 32'h00000000;
        endcase
    endfunction

    task automatic store_merge(input model_entry e);
        logic [7:0] idx;
        idx = e.addr[9:2];
        case (e.op)
            SW: mirror[idx] = e.data;
            SH: mirror[idx][16*e.addr[1] +: 16] = e.data[15:0];
            default: mirror[idx][8*e.addr[1:0] +: 8] = e.data[7:0];
        endcase
    endtask

    task automatic new_entry(output res_word r, output model_entry e);
        logic [31:0] rnd;
        logic        st;
        rnd = $random(seed);
        e.op = mem_op_t'(rnd[2:0]);
        st = (e.op == SB) || (e.op == SH) || (e.op == SW);
        e.tag = next_tag;
        e.addr = 32'h100 + (rnd[15:8] & 8'h3f);
        if (e.op == LW || e.op == SW) begin
            e.addr[1:0] = 2'b00;
        end else if (e.op == LH || e.op == LHU || e.op == SH) begin
            e.addr[0] = 1'b0;
        end
        e.base = 32'h100 + (rnd[23:16] & 8'h1c);
        e.data = $random(seed);
        rnd = $random(seed);
        e.pend1 = (rnd[1:0] == 2'b00);
        e.pend2 = st && (rnd[3:2] == 2'b00);
        e.cnt1 = 3'(rnd[15:8] % 7);
        e.cnt2 = 3'(rnd[23:16] % 7);
        r.op = e.op;
        r.src1_tag = e.tag;
        r.src1_valid = !e.pend1;
        // a pending source carries junk that must not be used
        r.src1_data = e.pend1 ? $random(seed) : e.base;
        r.src2_tag = e.tag ^ 3'd4;
        r.src2_valid = !e.pend2;
        r.src2_data = e.pend2 ? $random(seed) : e.data;
        r.imm = e.addr - e.base;
        r.rd_tag = e.tag;
    endtask

    task automatic step_cycle(input bit allow_dispatch, input bit allow_flush);
        model_entry  e;
        res_word     r;
        bit          do_flush;
        logic [31:0] rnd;
        @(posedge clk);
        #1;
        if (full_check) begin
            assert (full == (q.size() == `LSQ_DEPTH)) else begin
                errors++;
                $display("CHECK FAILED full got %0h expected %0h", full,
                         q.size() == `LSQ_DEPTH);
            end
        end
        if (finished_entry) begin
            finishes++;
            idle_cycles = 0;
            assert (q.size() > 0) else begin
                errors++;
                $display("entry with tag %0h finished but none was outstanding",
                         finished_data.tag);
            end
            if (q.size() > 0) begin
                e = q.pop_front();
                assert (finished_data.tag == e.tag) else begin
                    errors++;
                    $display("CHECK FAILED finished_data.tag got %0h expected %0h",
                             finished_data.tag, e.tag);
                end
                assert (finished_data.op == e.op) else begin
                    errors++;
                    $display("CHECK FAILED finished_data.op got %0h expected %0h",
                             finished_data.op, e.op);
                end
                if (e.op == SB || e.op == SH || e.op == SW) begin
                    assert (finished_data.value == 32'h00000000) else begin
                        errors++;
                        $display("CHECK FAILED finished_data.value got %0h expected 0",
                                 finished_data.value);
                    end
                    store_merge(e);
                end else begin
                    assert (finished_data.value ==
                            expect_load(e.op, mirror[e.addr[9:2]], e.addr[1:0])) else begin
                        errors++;
                        $display("CHECK FAILED finished_data.value got %0h expected %0h",
                                 finished_data.value,
                                 expect_load(e.op, mirror[e.addr[9:2]], e.addr[1:0]));
                    end
                end
            end
        end else begin
            idle_cycles++;
        end
        #1;
        load = 1'b0;
        flush_ip = 1'b0;
        robs_calculated = '0;
        rnd = $random(seed);
        do_flush = allow_flush && q.size() > 0 && (q[0].pend1 || q[0].pend2) &&
                   rnd[3:0] == 4'h0;
        if (do_flush) begin
            flush_ip = 1'b1;
            q.delete();
        end else begin
            if (allow_dispatch && !full && q.size() < `LSQ_DEPTH && rnd[4]) begin
                new_entry(r, e);
                res_in = r;
                load = 1'b1;
                q.push_back(e);
                next_tag = next_tag + 1'b1;
            end
            // late operands arrive on the cdb, zero delay lands in the dispatch cycle
            for (int i = 0; i < q.size(); i++) begin
                e = q[i];
                if (e.pend1 && e.cnt1 == 0) begin
                    robs_calculated[e.tag] = 1'b1;
                    cdb[e.tag].data = e.base;
                    e.pend1 = 1'b0;
                end else if (e.pend1) begin
                    e.cnt1 = e.cnt1 - 1'b1;
                end
                if (e.pend2 && e.cnt2 == 0) begin
                    robs_calculated[e.tag ^ 3'd4] = 1'b1;
                    cdb[e.tag ^ 3'd4].data = e.data;
                    e.pend2 = 1'b0;
                end else if (e.pend2) begin
                    e.cnt2 = e.cnt2 - 1'b1;
                end
                q[i] = e;
            end
        end
        rob_head_ptr = (q.size() > 0) ? q[0].tag : next_tag;
        if (idle_cycles > 400 && q.size() > 0) begin
            timeouts++;
            idle_cycles = 0;
            $display("timeout: the head entry made no progress for 400 cycles");
        end
    endtask

    // flush while a load waits for its memory response
    task automatic directed_flush();
        res_word r;
        int      n;
        for (n = 0; n < 400 && q.size() > 0; n++) begin
            step_cycle(0, 0);
        end
        if (q.size() > 0) begin
            timeouts++;
            $display("timeout: queue did not drain before the directed flush");
        end
        full_check = 1'b0;
        @(posedge clk);
        #2;
        r = '0;
        r.op = LW;
        r.src1_data = 32'h100;
        r.src1_valid = 1'b1;
        r.src2_valid = 1'b1;
        r.imm = 32'h4;
        r.rd_tag = next_tag;
        res_in = r;
        load = 1'b1;
        rob_head_ptr = next_tag;
        next_tag = next_tag + 1'b1;
        @(posedge clk);
        #2;
        load = 1'b0;
        for (n = 0; n < 20 && !dut0.req.read; n++) begin
            @(posedge clk);
            #1;
        end
        if (!dut0.req.read) begin
            timeouts++;
            $display("timeout: the directed load never reached memory");
        end
        #1;
        flush_ip = 1'b1;
        rob_head_ptr = next_tag;
        @(posedge clk);
        #2;
        flush_ip = 1'b0;
        for (n = 0; n < 2 * `LSQ_MEM_LATENCY + 4; n++) begin
            @(posedge clk);
            #1;
            assert (!finished_entry) else begin
                errors++;
                $display("a flushed load reported a finish with tag %0h",
                         finished_data.tag);
            end
        end
        for (n = 0; n < 20 && full; n++) begin
            @(posedge clk);
            #1;
        end
        if (full) begin
            timeouts++;
            $display("timeout: queue stayed full after the directed flush");
        end
        full_check = 1'b1;
    endtask

    initial begin
        logic [31:0] w;
        int          n;
        seed = 32'h89a1;
        errors = 0;
        timeouts = 0;
        finishes = 0;
        idle_cycles = 0;
        next_tag = '0;
        full_check = 1'b0;
        rst = 1'b0;
        load = 1'b0;
        flush_ip = 1'b0;
        res_in = '0;
        robs_calculated = '0;
        rob_head_ptr = '0;
        for (int t = 0; t < NTAGS; t++) begin
            cdb[t].data = 32'h0;
        end
        for (int i = 0; i < `LSQ_MEM_WORDS; i++) begin
            w = $random(seed);
            mirror[i] = w;
            dut0.u_mem.mem[i] = w;
        end
        repeat (8) @(posedge clk);
        #2;
        rst = 1'b1;
        #1;
        assert (full) else begin
            errors++;
            $display("CHECK FAILED full got %0h expected 1 in the RESET cycle", full);
        end
        for (n = 0; n < 4 && full; n++) begin
            @(posedge clk);
            #1;
        end
        if (full) begin
            timeouts++;
            $display("timeout: full stayed high after reset");
        end
        full_check = 1'b1;
        repeat (1500) step_cycle(1, 1);
        directed_flush();
        repeat (500) step_cycle(1, 1);
        for (n = 0; n < 400 && q.size() > 0; n++) begin
            step_cycle(0, 0);
        end
        if (q.size() > 0) begin
            timeouts++;
            $display("timeout: queue did not drain at the end of the run");
        end
        for (int i = 0; i < `LSQ_MEM_WORDS; i++) begin
            assert (dut0.u_mem.mem[i] == mirror[i]) else begin
                errors++;
                $display("CHECK FAILED mem[%0h] got %0h expected %0h", i,
                         dut0.u_mem.mem[i], mirror[i]);
            end
        end
        $display("errors %0d, timeouts %0d, finished entries %0d", errors, timeouts,
                 finishes);
        if (errors == 0 && timeouts == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* verilog/data_mem.sv */
`include "lsq_config.svh"
`default_nettype none

module data_mem
    import lsq_pkg::*;
(
    input  wire         clk,
    input  wire         rst,
    input  wire mem_req req,
    output logic        resp,
    output logic [31:0] rdata
);

    localparam int IDX_W = $clog2(`LSQ_MEM_WORDS);
    localparam int CNT_W = $clog2(`LSQ_MEM_LATENCY + 1);

    logic [31:0]      mem [`LSQ_MEM_WORDS];
    logic [CNT_W-1:0] lat_cnt;
    logic [IDX_W-1:0] idx;
    logic             active;

    assign active = req.read || req.write;
    assign idx = req.addr[IDX_W+1:2];
    assign resp = active && (lat_cnt == CNT_W'(`LSQ_MEM_LATENCY));
    assign rdata = mem[idx];

    // counts from the first request cycle
    always_ff @(posedge clk) begin
        if (!rst) begin
            lat_cnt <= '0;
        end else if (!active || resp) begin
            lat_cnt <= '0;
        end else begin
            lat_cnt <= lat_cnt + 1'b1;
        end
    end

    // byte merge lands in the resp cycle
    always_ff @(posedge clk) begin
        if (resp && req.write) begin
            for (int b = 0; b < 4; b++) begin
                if (req.mbe[b]) begin
                    mem[idx][8*b +: 8] <= req.wdata[8*b +: 8];
                end
            end
        end
    end

    a_write_mbe: assert property (@(posedge clk) disable iff (!rst)
        req.write |-> (req.mbe != 4'b0000));

endmodule

`default_nettype wire

/* verilog/load_align.sv */
`default_nettype none

module load_align
    import lsq_pkg::*;
(
    input  wire mem_op_t op,
    input  wire [1:0]    addr_offset,
    input  wire [31:0]   rdata,
    output logic [31:0]  value
);

    logic [31:0] byte_word;
    logic [31:0] half_word;

    // bring the addressed lane down to bit 0
    assign byte_word = rdata >> {addr_offset, 3'b000};
    assign half_word = rdata >> {addr_offset[1], 4'b0000};

    always_comb begin
        case (op)
            LB: begin
                value = {{24{byte_word[7]}}, byte_word[7:0]};
            end
            LBU: begin
                value = {24'h000000, byte_word[7:0]};
            end
            LH: begin
                value = {{16{half_word[15]}}, half_word[15:0]};
            end
            LHU: begin
                value = {16'h0000, half_word[15:0]};
            end
            LW: begin
                value = rdata;
            end
            // stores carry no result
            default: begin
                value = 32'h00000000;
            end
        endcase
    end

endmodule

`default_nettype wire

/* verilog/lsq.sv */
`include "lsq_config.svh"
`default_nettype none

module lsq
    import lsq_pkg::*;
(
    input  wire                           clk,
    input  wire                           rst,
    input  wire                           load,
    input  wire res_word                  res_in,
    input  wire                           flush_ip,
    input  wire cdb_data                  cdb [(1 << `LSQ_TAG_W)],
    input  wire [(1 << `LSQ_TAG_W)-1:0]   robs_calculated,
    input  wire [`LSQ_TAG_W-1:0]          rob_head_ptr,
    output logic                          full,
    output logic                          finished_entry,
    output logic [`LSQ_TAG_W-1:0]         head_tag,
    output mem_op_t                       head_op,
    output logic [1:0]                    addr_offset,
    output mem_req                        req,
    input  wire                           resp
);

    localparam int PTR_W = $clog2(`LSQ_DEPTH);

    res_word               entries [`LSQ_DEPTH];
    logic                  base_rdy [`LSQ_DEPTH];
    logic                  data_rdy [`LSQ_DEPTH];
    logic [`LSQ_DEPTH-1:0] alloc;
    logic [PTR_W-1:0]      head_ptr;
    logic [PTR_W-1:0]      tail_ptr;
    logic [PTR_W:0]        count;
    logic [PTR_W:0]        count_next;
    logic                  req_active;
    lsq_state_t            state;
    lsq_state_t            next_state;
    res_word               head;
    logic [31:0]           addr;
    logic                  head_ready;
    logic                  do_alloc;
    logic                  do_issue;
    logic                  do_retire;
    logic                  flush_clear;
    logic                  enter_flush;

    assign head = entries[head_ptr];
    assign addr = head.src1_data + head.imm;
    assign head_tag = head.rd_tag;
    assign head_op = head.op;
    assign addr_offset = addr[1:0];

    // stores also wait for their data operand
    assign head_ready = alloc[head_ptr] && base_rdy[head_ptr] &&
                        (data_rdy[head_ptr] || !is_store(head.op));

    assign full = (state == RESET) || (state == FULL) || (state == FLUSH);
    assign do_alloc = load && !full && !flush_ip;
    assign do_retire = resp && req_active;
    assign do_issue = (state != FLUSH) && !req_active && !flush_ip && head_ready &&
                      (head.rd_tag == rob_head_ptr);

    // an in-flight access must finish before the queue can be dropped
    assign enter_flush = (state != FLUSH) && flush_ip && req_active && !resp;
    assign flush_clear = (state == FLUSH) ? resp : (flush_ip && !enter_flush);
    assign finished_entry = do_retire && (state != FLUSH);

    assign count_next = count + {{PTR_W{1'b0}}, do_alloc} - {{PTR_W{1'b0}}, do_retire};

    always_comb begin
        req.read = req_active && !is_store(head.op);
        req.write = req_active && is_store(head.op);
        req.addr = addr;
        case (head.op)
            LW, SW: begin
                req.mbe = 4'b1111;
                req.wdata = head.src2_data;
            end
            LH, LHU, SH: begin
                req.mbe = 4'b0011 << addr[1:0];
                req.wdata = {2{head.src2_data[15:0]}};
            end
            default: begin
                req.mbe = 4'b0001 << addr[1:0];
                req.wdata = {4{head.src2_data[7:0]}};
            end
        endcase
    end

    always_comb begin
        next_state = state;
        case (state)
            RESET: next_state = IDLE;
            FLUSH: begin
                if (resp) begin
                    next_state = IDLE;
                end
            end
            default: begin
                if (enter_flush) begin
                    next_state = FLUSH;
                end else if (flush_clear || count_next == '0) begin
                    next_state = IDLE;
                end else if (count_next == (PTR_W + 1)'(`LSQ_DEPTH)) begin
                    next_state = FULL;
                end else begin
                    next_state = ACTIVE;
                end
            end
        endcase
    end

    // entry payload and operand capture
    always_ff @(posedge clk) begin
        for (int i = 0; i < `LSQ_DEPTH; i++) begin
            if (alloc[i] && !base_rdy[i] && robs_calculated[entries[i].src1_tag]) begin
                entries[i].src1_data <= cdb[entries[i].src1_tag].data;
                base_rdy[i] <= 1'b1;
            end
            if (alloc[i] && !data_rdy[i] && robs_calculated[entries[i].src2_tag]) begin
                entries[i].src2_data <= cdb[entries[i].src2_tag].data;
                data_rdy[i] <= 1'b1;
            end
        end
        if (do_alloc) begin
            entries[tail_ptr] <= res_in;
            if (!res_in.src1_valid && robs_calculated[res_in.src1_tag]) begin
                entries[tail_ptr].src1_data <= cdb[res_in.src1_tag].data;
            end
            if (!res_in.src2_valid && robs_calculated[res_in.src2_tag]) begin
                entries[tail_ptr].src2_data <= cdb[res_in.src2_tag].data;
            end
            base_rdy[tail_ptr] <= res_in.src1_valid || robs_calculated[res_in.src1_tag];
            data_rdy[tail_ptr] <= res_in.src2_valid || robs_calculated[res_in.src2_tag];
        end
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            state <= RESET;
            alloc <= '0;
            head_ptr <= '0;
            tail_ptr <= '0;
            count <= '0;
            req_active <= 1'b0;
        end else begin
            state <= next_state;
            if (flush_clear) begin
                alloc <= '0;
                head_ptr <= '0;
                tail_ptr <= '0;
                count <= '0;
                req_active <= 1'b0;
            end else begin
                if (do_alloc) begin
                    alloc[tail_ptr] <= 1'b1;
                    tail_ptr <= tail_ptr + 1'b1;
                end
                if (do_retire) begin
                    alloc[head_ptr] <= 1'b0;
                    head_ptr <= head_ptr + 1'b1;
                    req_active <= 1'b0;
                end else if (do_issue) begin
                    req_active <= 1'b1;
                end
                count <= count_next;
            end
        end
    end

    // a request only ends with its response, even across a flush
    a_req_held: assert property (@(posedge clk) disable iff (!rst)
        (req.read || req.write) && !resp |=> $stable({req.read, req.write}));

    // memory samples the address over several cycles
    a_addr_stable: assert property (@(posedge clk) disable iff (!rst)
        (req.read || req.write) && !resp |=> $stable(req.addr));

    a_resp_has_req: assert property (@(posedge clk) disable iff (!rst)
        resp |-> (req.read || req.write));

endmodule

`default_nettype wire

/* verilog/lsq_config.svh */
`ifndef LSQ_CONFIG_SVH
`define LSQ_CONFIG_SVH

`default_nettype none

// load/store queue entries, must be a power of two
`define LSQ_DEPTH 4

// rob tag width, gives 8 rob slots
`define LSQ_TAG_W 3

// data memory size in 32-bit words
`define LSQ_MEM_WORDS 256

// cycles from first request cycle to the response pulse
`define LSQ_MEM_LATENCY 3

`default_nettype wire

`endif

/* verilog/lsq_pkg.sv */
`include "lsq_config.svh"
`default_nettype none

package lsq_pkg;

    typedef enum logic [2:0] {
        LB,
        LH,
        LW,
        LBU,
        LHU,
        SB,
        SH,
        SW
    } mem_op_t;

    function automatic logic is_store(mem_op_t op);
        return (op == SB) || (op == SH) || (op == SW);
    endfunction

    // dispatch word, src1 is the base and src2 the store data
    typedef struct packed {
        mem_op_t                op;
        logic [`LSQ_TAG_W-1:0]  src1_tag;
        logic [31:0]            src1_data;
        logic                   src1_valid;
        logic [`LSQ_TAG_W-1:0]  src2_tag;
        logic [31:0]            src2_data;
        logic                   src2_valid;
        logic [31:0]            imm;
        logic [`LSQ_TAG_W-1:0]  rd_tag;
    } res_word;

    typedef struct packed {
        logic [31:0] data;
    } cdb_data;

    typedef struct packed {
        logic        read;
        logic        write;
        logic [31:0] addr;
        logic [31:0] wdata;
        logic [3:0]  mbe;
    } mem_req;

    typedef struct packed {
        logic [`LSQ_TAG_W-1:0] tag;
        mem_op_t               op;
        logic [31:0]           value;
    } finished_word;

    typedef enum logic [2:0] {
        RESET,
        IDLE,
        ACTIVE,
        FULL,
        FLUSH
    } lsq_state_t;

endpackage

`default_nettype wire

/* verilog/mem_unit.sv */
`include "lsq_config.svh"
`default_nettype none

module mem_unit
    import lsq_pkg::*;
(
    input  wire                         clk,
    input  wire                         rst,
    input  wire                         load,
    input  wire res_word                res_in,
    input  wire                         flush_ip,
    input  wire cdb_data                cdb [(1 << `LSQ_TAG_W)],
    input  wire [(1 << `LSQ_TAG_W)-1:0] robs_calculated,
    input  wire [`LSQ_TAG_W-1:0]        rob_head_ptr,
    output logic                        full,
    output logic                        finished_entry,
    output finished_word                finished_data
);

    mem_req                req;
    logic                  resp;
    logic [31:0]           rdata;
    logic [`LSQ_TAG_W-1:0] head_tag;
    mem_op_t               head_op;
    logic [1:0]            addr_offset;
    logic [31:0]           value;

    lsq u_lsq (
        .clk             (clk),
        .rst             (rst),
        .load            (load),
        .res_in          (res_in),
        .flush_ip        (flush_ip),
        .cdb             (cdb),
        .robs_calculated (robs_calculated),
        .rob_head_ptr    (rob_head_ptr),
        .full            (full),
        .finished_entry  (finished_entry),
        .head_tag        (head_tag),
        .head_op         (head_op),
        .addr_offset     (addr_offset),
        .req             (req),
        .resp            (resp)
    );

    data_mem u_mem (
        .clk   (clk),
        .rst   (rst),
        .req   (req),
        .resp  (resp),
        .rdata (rdata)
    );

    load_align u_align (
        .op          (head_op),
        .addr_offset (addr_offset),
        .rdata       (rdata),
        .value       (value)
    );

    // head entry is still in place during the resp cycle
    assign finished_data.tag = head_tag;
    assign finished_data.op = head_op;
    assign finished_data.value = value;

endmodule

`default_nettype wire
